// File: pacRenderPkg.sv
// pacRender shared definitions
// widths, entity and class codes, sprite sheet tile layout, fixed colors
package pacRenderPkg;

	// ------------------------------------------------------------
	// widths and sizes
	// ------------------------------------------------------------
	localparam int tileSize  = 16;   // sprite tile edge in pixels
	localparam int tileBits  = 4;    // coordinate inside a tile
	localparam int sheetDim  = 128;  // sheet edge, 8x8 tiles
	localparam int mazeDim   = 128;  // maze picture edge
	localparam int coordBits = 7;    // sheet or maze coordinate
	localparam int addrBits  = 14;   // row * 128 + column
	localparam int colorBits = 24;   // packed RGB
	localparam int frameBits = 4;    // animation frame count

	localparam int tileIdxBits = coordBits - tileBits;  // tile row/col index

	// ------------------------------------------------------------
	// codes
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		entNone       = 3'd0,
		entPlayer     = 3'd1,
		entBackground = 3'd2,
		entBlinky     = 3'd3,
		entPinky      = 3'd4,
		entInky       = 3'd5,
		entClyde      = 3'd6,
		entPellet     = 3'd7
	} entityT;

	typedef enum logic [1:0] {
		dirUp,
		dirLeft,
		dirDown,
		dirRight
	} dirT;

	// how stage 3 builds the final color
	typedef enum logic [1:0] {
		clsSprite,   // sheet texel over maze texel
		clsMaze,     // maze texel only
		clsPellet,   // fixed pellet color
		clsBlack
	} classT;

	// ------------------------------------------------------------
	// tile layout and colors
	// ------------------------------------------------------------
	localparam int playerClosedCol = 0;  // one closed pose for all directions
	localparam int playerClosedRow = 0;
	localparam int playerWideCol   = 4;  // cols 4..7 in dirT order
	localparam int playerWideRow   = 0;
	localparam int playerHalfRow   = 1;  // half-open shares cols 4..7
	localparam int ghostBaseRow    = 2;  // ghost n on row 2+n
	localparam int ghostPoseBCol   = 4;  // pose A in cols 0..3, pose B in 4..7

	localparam logic [colorBits-1:0] pelletColor      = 24'hfab9b0;
	localparam logic [colorBits-1:0] transparentColor = '0;  // black texel

endpackage

// File: colorRam.sv
`timescale 1ns/1ps
// 16K x 24-bit color memory
// loader write port and one registered read port, read-before-write
module colorRam (
	input  logic                              Clk,
	input  logic                              writeEnable,
	input  logic [pacRenderPkg::addrBits-1:0]  writeAddr,
	input  logic [pacRenderPkg::addrBits-1:0]  readAddr,
	input  logic [pacRenderPkg::colorBits-1:0] writeData,
	output logic [pacRenderPkg::colorBits-1:0] readData
);
	import pacRenderPkg::*;

	logic [colorBits-1:0] mem [0:(1 << addrBits) - 1];  // no reset, filled by loader

	always_ff @(posedge Clk)
	begin
		if (writeEnable)
			mem[writeAddr] <= writeData;
	end

	// same-address read returns the old word
	always_ff @(posedge Clk)
	begin
		readData <= mem[readAddr];
	end

	// loader must present a clean address with each write
	writeAddrKnown: assert property (@(posedge Clk)
		writeEnable |-> !$isunknown(writeAddr));

endmodule

// File: spriteAddrGen.sv
`timescale 1ns/1ps
// pacRender stage 1
// animation frame count, sprite tile selection, registered sheet and maze addresses
module spriteAddrGen (
	input  logic                              Clk,
	input  logic                              reset,
	input  logic                              pixelValid,
	input  pacRenderPkg::entityT              entity,
	input  pacRenderPkg::dirT                 direction,
	input  logic [pacRenderPkg::tileBits-1:0]  spriteX,
	input  logic [pacRenderPkg::tileBits-1:0]  spriteY,
	input  logic [pacRenderPkg::coordBits-1:0] mazeX,
	input  logic [pacRenderPkg::coordBits-1:0] mazeY,
	input  logic                              frameTick,
	output logic [pacRenderPkg::addrBits-1:0]  sheetAddr,
	output logic [pacRenderPkg::addrBits-1:0]  mazeAddr,
	output logic                              stage1Valid,
	output pacRenderPkg::classT               stage1Class
);
	import pacRenderPkg::*;

	logic [frameBits-1:0]   frameCount;     // animation phase
	logic                   playerClosed;   // counts 0..3
	logic                   playerWide;     // counts 8..12
	logic                   ghostPoseA;     // counts 0..3 and 8..11
	logic [tileIdxBits-1:0] tileCol;
	logic [tileIdxBits-1:0] tileRow;
	logic [coordBits-1:0]   sheetX;
	logic [coordBits-1:0]   sheetY;
	logic [addrBits-1:0]    sheetAddrNext;
	logic [addrBits-1:0]    mazeAddrNext;
	classT                  pixClass;

	// ------------------------------------------------------------
	// frame count
	// ------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (reset)
			frameCount <= '0;
		else if (frameTick)
			frameCount <= frameCount + 1'b1;  // wraps after 16 ticks
	end

	assign playerClosed = (frameCount <= frameBits'(3));
	assign playerWide   = (frameCount >= frameBits'(8)) && (frameCount <= frameBits'(12));
	assign ghostPoseA   = ~frameCount[2];  // bit 2 low in 0..3 and 8..11

	// ------------------------------------------------------------
	// tile pick and class
	// ------------------------------------------------------------
	always_comb
	begin
		tileCol  = tileIdxBits'(playerClosedCol);
		tileRow  = tileIdxBits'(playerClosedRow);
		pixClass = clsBlack;
		unique case (entity)
			entPlayer:
			begin
				pixClass = clsSprite;
				if (playerClosed)
				begin
					tileCol = tileIdxBits'(playerClosedCol);  // same for all directions
					tileRow = tileIdxBits'(playerClosedRow);
				end
				else if (playerWide)
				begin
					tileCol = tileIdxBits'(playerWideCol) + tileIdxBits'(direction);
					tileRow = tileIdxBits'(playerWideRow);
				end
				else
				begin
					tileCol = tileIdxBits'(playerWideCol) + tileIdxBits'(direction);
					tileRow = tileIdxBits'(playerHalfRow);  // half-open
				end
			end
			entBlinky, entPinky, entInky, entClyde:
			begin
				pixClass = clsSprite;
				tileRow  = tileIdxBits'(ghostBaseRow) + tileIdxBits'(entity - entBlinky);
				if (ghostPoseA)
					tileCol = tileIdxBits'(direction);
				else
					tileCol = tileIdxBits'(ghostPoseBCol) + tileIdxBits'(direction);
			end
			entBackground: pixClass = clsMaze;
			entPellet:     pixClass = clsPellet;
			default:       pixClass = clsBlack;  // entNone
		endcase
	end

	// tile origin plus offset inside the tile
	assign sheetX = coordBits'(tileCol * tileSize) + coordBits'(spriteX);
	assign sheetY = coordBits'(tileRow * tileSize) + coordBits'(spriteY);

	assign sheetAddrNext = (pixClass == clsSprite) ?
		addrBits'(sheetY) * addrBits'(sheetDim) + addrBits'(sheetX) : '0;
	assign mazeAddrNext = (pixClass == clsSprite || pixClass == clsMaze) ?
		addrBits'(mazeY) * addrBits'(mazeDim) + addrBits'(mazeX) : '0;  // zero for pellet/black

	// ------------------------------------------------------------
	// stage 1 registers
	// ------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (reset)
			stage1Valid <= 1'b0;
		else
			stage1Valid <= pixelValid;
	end

	always_ff @(posedge Clk)
	begin
		sheetAddr   <= sheetAddrNext;
		mazeAddr    <= mazeAddrNext;
		stage1Class <= pixClass;
	end

	// count stays defined once out of reset
	frameCountKnown: assert property (@(posedge Clk) disable iff (reset)
		!$isunknown(frameCount));

endmodule

// File: pixelCompositor.sv
`timescale 1ns/1ps
// pacRender stage 3
// picks the final RGB value from the pixel class and the two texels
module pixelCompositor (
	input  logic                              Clk,
	input  logic                              reset,
	input  logic                              inValid,
	input  pacRenderPkg::classT               pixelClass,
	input  logic [pacRenderPkg::colorBits-1:0] sheetTexel,
	input  logic [pacRenderPkg::colorBits-1:0] mazeTexel,
	output logic                              outValid,
	output logic [pacRenderPkg::colorBits-1:0] outColor
);
	import pacRenderPkg::*;

	logic [colorBits-1:0] colorNext;
	logic                 sheetClear;  // black texel shows maze

	assign sheetClear = (sheetTexel == transparentColor);

	always_comb
	begin
		unique case (pixelClass)
			clsSprite: colorNext = sheetClear ? mazeTexel : sheetTexel;
			clsMaze:   colorNext = mazeTexel;
			clsPellet: colorNext = pelletColor;
			default:   colorNext = '0;  // clsBlack
		endcase
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge Clk)
	begin
		outColor <= colorNext;
	end

	// a valid pixel carries a defined class
	classKnown: assert property (@(posedge Clk) disable iff (reset)
		inValid |-> !$isunknown(pixelClass));

endmodule

// File: pacRender.sv
`timescale 1ns/1ps
// pacRender top level
// address stage, sheet and maze RAMs, compositor, loader write decode
module pacRender (
	input  logic                              Clk,
	input  logic                              reset,
	// pixel stream
	input  logic                              pixelValid,
	input  pacRenderPkg::entityT              entity,
	input  pacRenderPkg::dirT                 direction,
	input  logic [pacRenderPkg::tileBits-1:0]  spriteX,
	input  logic [pacRenderPkg::tileBits-1:0]  spriteY,
	input  logic [pacRenderPkg::coordBits-1:0] mazeX,
	input  logic [pacRenderPkg::coordBits-1:0] mazeY,
	input  logic                              frameTick,
	// loader
	input  logic                              memWrite,
	input  logic                              memSelect,  // 0 sheet, 1 maze
	input  logic [pacRenderPkg::addrBits-1:0]  memAddr,
	input  logic [pacRenderPkg::colorBits-1:0] memData,
	// composited pixel
	output logic                              outValid,
	output logic [pacRenderPkg::colorBits-1:0] outColor
);
	import pacRenderPkg::*;

	logic [addrBits-1:0]  sheetAddr;
	logic [addrBits-1:0]  mazeAddr;
	logic                 stage1Valid;
	classT                stage1Class;
	logic                 stage2Valid;   // aligned with RAM data
	classT                stage2Class;
	logic [colorBits-1:0] sheetTexel;
	logic [colorBits-1:0] mazeTexel;
	logic                 sheetWrite;
	logic                 mazeWrite;

	assign sheetWrite = memWrite & ~memSelect;
	assign mazeWrite  = memWrite & memSelect;

	spriteAddrGen addrGen (
		.Clk         (Clk),
		.reset       (reset),
		.pixelValid  (pixelValid),
		.entity      (entity),
		.direction   (direction),
		.spriteX     (spriteX),
		.spriteY     (spriteY),
		.mazeX       (mazeX),
		.mazeY       (mazeY),
		.frameTick   (frameTick),
		.sheetAddr   (sheetAddr),
		.mazeAddr    (mazeAddr),
		.stage1Valid (stage1Valid),
		.stage1Class (stage1Class)
	);

	colorRam sheetRam (
		.Clk         (Clk),
		.writeEnable (sheetWrite),
		.writeAddr   (memAddr),
		.readAddr    (sheetAddr),
		.writeData   (memData),
		.readData    (sheetTexel)
	);

	colorRam mazeRam (
		.Clk         (Clk),
		.writeEnable (mazeWrite),
		.writeAddr   (memAddr),
		.readAddr    (mazeAddr),
		.writeData   (memData),
		.readData    (mazeTexel)
	);

	// ------------------------------------------------------------
	// stage 2, class and valid ride alongside the RAM read
	// ------------------------------------------------------------
	always_ff @(posedge Clk)
	begin
		if (reset)
			stage2Valid <= 1'b0;
		else
			stage2Valid <= stage1Valid;
	end

	always_ff @(posedge Clk)
	begin
		stage2Class <= stage1Class;
	end

	pixelCompositor compositor (
		.Clk        (Clk),
		.reset      (reset),
		.inValid    (stage2Valid),
		.pixelClass (stage2Class),
		.sheetTexel (sheetTexel),
		.mazeTexel  (mazeTexel),
		.outValid   (outValid),
		.outColor   (outColor)
	);

endmodule

// File: tbPacRenderRef.svh
// pacRender testbench reference model
// shadow memories, LFSR stimulus source, expected pixel color
`ifndef tbPacRenderRefSvh
`define tbPacRenderRefSvh

logic [colorBits-1:0] sheetShadow [0:(1 << addrBits) - 1];  // mirrors sheetRam
logic [colorBits-1:0] mazeShadow  [0:(1 << addrBits) - 1];  // mirrors mazeRam
logic [31:0]          lfsrState = 32'hf70e_7f75;

// fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] bits;
	logic        feedback;
	bits = '0;
	for (int i = 0; i < n; i++)
	begin
		feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		bits      = {bits[30:0], feedback};
	end
	return bits;
endfunction

// ------------------------------------------------------------
// expected color from tile layout, animation and class rules
// ------------------------------------------------------------
function automatic logic [colorBits-1:0] expectedColor(input entityT ent, input dirT dir,
	input logic [tileBits-1:0] sx, input logic [tileBits-1:0] sy,
	input logic [coordBits-1:0] mx, input logic [coordBits-1:0] my, input int frame);
	int                   col;
	int                   row;
	logic [colorBits-1:0] backdrop;
	logic [colorBits-1:0] texel;
	backdrop = mazeShadow[int'(my) * mazeDim + int'(mx)];
	case (ent)
		entBackground: return backdrop;
		entPellet:     return pelletColor;
		entPlayer:
		begin
			row = (frame >= 8 && frame <= 12) ? 0 : 1;  // wide-open or half-open
			col = 4 + int'(dir);
			if (frame <= 3)
			begin
				row = 0;  // closed mouth, any direction
				col = 0;
			end
		end
		entBlinky, entPinky, entInky, entClyde:
		begin
			row = 2 + int'(ent) - int'(entBlinky);
			col = (frame <= 3 || (frame >= 8 && frame <= 11)) ? int'(dir) : 4 + int'(dir);
		end
		default:       return '0;  // unknown code shows black
	endcase
	texel = sheetShadow[(row * tileSize + int'(sy)) * sheetDim + col * tileSize + int'(sx)];
	return (texel == '0) ? backdrop : texel;  // black texel is see-through
endfunction

`endif

// File: tbPacRender.sv
`timescale 1ns/1ps
// pacRender testbench
// loads both RAMs, streams pixels back to back, checks color and 3-cycle latency
module tbPacRender;
	import pacRenderPkg::*;

	localparam int loaderCycles  = 2 * (1 << addrBits);        // sheet then maze
	localparam int numPixels     = 3 * 8 + 20 * 5 * 4 * 4;      // fixed codes plus sprites
	localparam int timeoutCycles = 2 * loaderCycles + numPixels;

	logic                 Clk;
	logic                 reset;
	logic                 pixelValid;
	entityT               entity;
	dirT                  direction;
	logic [tileBits-1:0]  spriteX;
	logic [tileBits-1:0]  spriteY;
	logic [coordBits-1:0] mazeX;
	logic [coordBits-1:0] mazeY;
	logic                 frameTick;
	logic                 memWrite;
	logic                 memSelect;
	logic [addrBits-1:0]  memAddr;
	logic [colorBits-1:0] memData;
	logic                 outValid;
	logic [colorBits-1:0] outColor;

	int                   cycles = 0;
	int                   tbFrame = 0;   // model of the frame count
	int                   checks = 0;
	int                   valueErrors = 0;
	int                   timingErrors = 0;
	logic [colorBits-1:0] expQ [$];      // pixels in flight
	int                   dueQ [$];
	int                   frameQ [$];
	string                nameQ [$];

	`include "tbPacRenderRef.svh"

	pacRender dut (.*);

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	always @(posedge Clk)
		cycles <= cycles + 1;

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic loadMemories();
		logic [colorBits-1:0] word;
		for (int sel = 0; sel < 2; sel++)
		begin
			for (int a = 0; a < (1 << addrBits); a++)
			begin
				word = colorBits'(takeBits(colorBits));
				if (sel == 0 && takeBits(2) == 0)
					word = '0;  // about 1 in 4 sheet texels transparent
				if (sel == 0)
					sheetShadow[a] = word;
				else
					mazeShadow[a] = word;
				memWrite  = 1'b1;
				memSelect = sel[0];
				memAddr   = addrBits'(a);
				memData   = word;
				@(posedge Clk);
				#2;
			end
		end
		memWrite = 1'b0;
	endtask

	task automatic sendPixel(input string testName, input entityT ent, input dirT dir,
		input logic tick);
		logic [tileBits-1:0]  sx;
		logic [tileBits-1:0]  sy;
		logic [coordBits-1:0] mx;
		logic [coordBits-1:0] my;
		sx = tileBits'(takeBits(tileBits));
		sy = tileBits'(takeBits(tileBits));
		mx = coordBits'(takeBits(coordBits));
		my = coordBits'(takeBits(coordBits));
		expQ.push_back(expectedColor(ent, dir, sx, sy, mx, my, tbFrame));
		dueQ.push_back(cycles + 3);  // three register stages
		frameQ.push_back(tbFrame);
		nameQ.push_back(testName);
		pixelValid = 1'b1;
		entity     = ent;
		direction  = dir;
		spriteX    = sx;
		spriteY    = sy;
		mazeX      = mx;
		mazeY      = my;
		frameTick  = tick;
		if (tick)
			tbFrame = (tbFrame + 1) % 16;  // count moves after this pixel
		@(posedge Clk);
		#2;
	endtask

	// ------------------------------------------------------------
	// output compare at mid-cycle
	// ------------------------------------------------------------
	always @(negedge Clk)
	begin
		logic [colorBits-1:0] exp;
		int                   due;
		int                   frame;
		string                name;
		if (cycles > 0 && outValid === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				timingErrors++;
				$display("outValid high at cycle %0d with no pixel in flight", cycles);
			end
			else
			begin
				exp   = expQ.pop_front();
				due   = dueQ.pop_front();
				frame = frameQ.pop_front();
				name  = nameQ.pop_front();
				checks++;
				if (due != cycles)
				begin
					timingErrors++;
					$display("%s pixel came out at cycle %0d, due at %0d", name, cycles, due);
				end
				if (outColor !== exp)
				begin
					valueErrors++;
					$display("Fail %s frame %0d: expected %h actual %h", name, frame, exp, outColor);
				end
			end
		end
		else if (cycles > 0 && outValid !== 1'b0)
		begin
			timingErrors++;
			$display("outValid is unknown at cycle %0d", cycles);
		end
		else if (cycles > 0 && expQ.size() != 0 && dueQ[0] <= cycles)
		begin
			timingErrors++;
			$display("outValid low at cycle %0d where a %s pixel was due", cycles, nameQ[0]);
			void'(expQ.pop_front());
			void'(dueQ.pop_front());
			void'(frameQ.pop_front());
			void'(nameQ.pop_front());
		end
	end

	always @(posedge Clk)
	begin
		if (cycles >= timeoutCycles)
		begin
			$display("run stopped after %0d cycles, pipeline never drained", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		entityT fixedCodes [3] = '{entBackground, entPellet, entNone};
		entityT ent;
		dirT    dir;
		reset      = 1'b1;
		pixelValid = 1'b0;
		entity     = entNone;
		direction  = dirUp;
		spriteX    = '0;
		spriteY    = '0;
		mazeX      = '0;
		mazeY      = '0;
		frameTick  = 1'b0;
		memWrite   = 1'b0;
		memSelect  = 1'b0;
		memAddr    = '0;
		memData    = '0;
		repeat (4) @(posedge Clk);
		#2;
		reset = 1'b0;
		repeat (3) @(posedge Clk);  // idle, outValid must stay low
		#2;
		loadMemories();
		foreach (fixedCodes[i])
			for (int p = 0; p < 8; p++)
				sendPixel({"fixed ", fixedCodes[i].name()}, fixedCodes[i], dirT'(p % 4), 1'b0);
		// frames 16..19 repeat 0..3 after the wrap
		for (int f = 0; f < 20; f++)
			for (int e = 0; e < 5; e++)
				for (int d = 0; d < 4; d++)
					for (int p = 0; p < 4; p++)
					begin
						ent = (e == 0) ? entPlayer : entityT'(int'(entBlinky) + e - 1);
						dir = dirT'(d);
						sendPixel($sformatf("%s %s", ent.name(), dir.name()), ent, dir,
							e == 4 && d == 3 && p == 3);  // last pixel of the frame ticks
					end
		pixelValid = 1'b0;
		frameTick  = 1'b0;
		while (expQ.size() != 0)
			@(posedge Clk);
		repeat (2) @(posedge Clk);
		if (checks != numPixels)
			$display("only %0d of %0d pixels came out", checks, numPixels);
		$display("checks %0d, value errors %0d, timing errors %0d",
			checks, valueErrors, timingErrors);
		if (valueErrors == 0 && timingErrors == 0 && checks == numPixels)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: pacRender.f
+incdir+.
pacRenderPkg.sv
colorRam.sv
spriteAddrGen.sv
pixelCompositor.sv
pacRender.sv
tbPacRender.sv

// File: Makefile
# pacRender simulation with Verilator

.PHONY: help test clean

help:
	@echo "make test   build and run the pacRender testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tbPacRender \
		-Mdir obj_dir -o simTb -f pacRender.f
	@out=$$(./obj_dir/simTb); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
